/* hw/taskwait_in_pkg.sv */
package taskwait_in_pkg;

    // stream sizes.
    localparam int num_sources = 3;  // taskwait, ack and spawn-queue streams.
    localparam int data_width  = 64; // one task beat.
    localparam int id_width    = 8;  // task id carried with every beat.

    // one beat of task data.
    typedef logic [data_width-1:0] tw_data_t;

    // task id of the beat.
    typedef logic [id_width-1:0] tw_id_t;

    // index of one input stream, 0 to num_sources-1.
    typedef logic [1:0] src_idx_t;

    // one bit per input stream.
    typedef logic [num_sources-1:0] src_mask_t;

    // grant FSM states.
    // idle picks a source; busy holds it until the last beat.
    typedef enum logic {
        grant_idle = 1'b0, // no source owns the output.
        grant_busy = 1'b1  // a packet is being forwarded.
    } grant_state_e;

endpackage

/* hw/axis_stream_if.sv */
`timescale 1ns/1ns

// one AXI-stream link with id and last.
// the merge uses it for each input and for the output.
interface axis_stream_if;

    logic                      valid; // beat offered.
    logic                      ready; // beat accepted.
    taskwait_in_pkg::tw_data_t data;  // task payload.
    taskwait_in_pkg::tw_id_t   id;    // task id.
    logic                      last;  // final beat of the packet.

    // side that produces beats.
    modport source (
        output valid,
        output data,
        output id,
        output last,
        input  ready
    );

    // side that consumes beats.
    modport sink (
        input  valid,
        input  data,
        input  id,
        input  last,
        output ready
    );

endinterface

/* hw/grant_fsm.sv */
`timescale 1ns/1ns

module grant_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  taskwait_in_pkg::src_mask_t  request,     // valid of each source.
    input  taskwait_in_pkg::src_idx_t   prio,        // first source to look at.
    input  logic                        packet_done, // last beat taken.
    output taskwait_in_pkg::src_idx_t   grant,       // source that owns the output.
    output logic                        grant_active // grant is valid.
);

    taskwait_in_pkg::grant_state_e state;

    taskwait_in_pkg::src_idx_t pick;  // winner of this cycle's search.
    logic                      found; // some source is requesting.
    logic [2:0]                cand;  // prio plus offset, before the wrap.

    // search upward from prio, wrapping at num_sources.
    // the first requesting source wins.
    always_comb begin
        pick  = prio;
        found = 1'b0;
        cand  = '0;
        for (int i = 0; i < taskwait_in_pkg::num_sources; i++) begin
            cand = {1'b0, prio} + 3'(i);
            if (cand >= 3'(taskwait_in_pkg::num_sources)) begin
                cand = cand - 3'(taskwait_in_pkg::num_sources); // wrap around.
            end
            if (!found && request[cand[1:0]]) begin
                pick  = cand[1:0];
                found = 1'b1;
            end
        end
    end

    // grant is registered on the edge that leaves idle.
    // it then holds for the whole packet.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= taskwait_in_pkg::grant_idle;
            grant <= '0;
        end else begin
            case (state)
                taskwait_in_pkg::grant_idle: begin
                    if (found) begin
                        grant <= pick;                      // lock the winner.
                        state <= taskwait_in_pkg::grant_busy;
                    end
                end
                taskwait_in_pkg::grant_busy: begin
                    if (packet_done) begin
                        state <= taskwait_in_pkg::grant_idle; // rearbitrate next cycle.
                    end
                end
                default: begin
                    state <= taskwait_in_pkg::grant_idle;
                end
            endcase
        end
    end

    assign grant_active = (state == taskwait_in_pkg::grant_busy);

    // the owner cannot change in the middle of a packet.
    a_grant_stable: assert property (
        @(posedge clk) disable iff (rst)
        (state == taskwait_in_pkg::grant_busy) |=> $stable(grant)
    ) else $error("grant changed while busy.");

    // merge_slice only sees ready while busy, so no packet ends in idle.
    a_done_in_busy: assert property (
        @(posedge clk) disable iff (rst)
        packet_done |-> (state == taskwait_in_pkg::grant_busy)
    ) else $error("packet_done seen in idle.");

endmodule

/* hw/rr_pointer.sv */
`timescale 1ns/1ns

// round-robin priority.
// after a packet the next source up gets first pick,
// so the one just served drops to the lowest priority.
module rr_pointer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      packet_done, // last beat of the grant taken.
    input  taskwait_in_pkg::src_idx_t grant,       // source just served.
    output taskwait_in_pkg::src_idx_t prio         // first source to search.
);

    taskwait_in_pkg::src_idx_t next_prio;

    // successor of grant, wrapping at num_sources.
    always_comb begin
        if (grant >= taskwait_in_pkg::src_idx_t'(taskwait_in_pkg::num_sources - 1)) begin
            next_prio = '0;
        end else begin
            next_prio = grant + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prio <= '0; // source 0 first after reset.
        end else if (packet_done) begin
            prio <= next_prio;
        end
    end

    // prio and the grant it is loaded from stay inside the source range.
    a_prio_range: assert property (
        @(posedge clk) disable iff (rst)
        (prio < taskwait_in_pkg::src_idx_t'(taskwait_in_pkg::num_sources)) &&
        (!packet_done || grant < taskwait_in_pkg::src_idx_t'(taskwait_in_pkg::num_sources))
    ) else $error("prio or grant out of range.");

endmodule

/* hw/merge_slice.sv */
`timescale 1ns/1ns

module merge_slice (
    input  logic                      clk,
    input  logic                      rst,
    axis_stream_if.sink               src [taskwait_in_pkg::num_sources], // input streams.
    axis_stream_if.source             dst,          // merged output.
    input  taskwait_in_pkg::src_idx_t grant,        // source that owns the output.
    input  logic                      grant_active, // grant is valid.
    output logic                      packet_done   // last beat taken this edge.
);

    // input side unpacked from the interface array.
    taskwait_in_pkg::src_mask_t src_valid;
    taskwait_in_pkg::src_mask_t src_last;
    taskwait_in_pkg::src_mask_t src_ready;
    taskwait_in_pkg::tw_data_t  src_data [taskwait_in_pkg::num_sources];
    taskwait_in_pkg::tw_id_t    src_id [taskwait_in_pkg::num_sources];

    // granted source.
    logic                      sel_valid;
    logic                      sel_last;
    taskwait_in_pkg::tw_data_t sel_data;
    taskwait_in_pkg::tw_id_t   sel_id;

    logic in_ready; // room in the buffer while a grant is held.
    logic in_fire;  // beat taken from the granted source.
    logic out_fire; // beat taken by the output.

    // two-entry buffer.
    taskwait_in_pkg::tw_data_t buf_data [2];
    taskwait_in_pkg::tw_id_t   buf_id [2];
    logic [1:0]                buf_last;
    logic                      wr_ptr;
    logic                      rd_ptr;
    logic [1:0]                count;   // entries held, 0 to 2.

    for (genvar g = 0; g < taskwait_in_pkg::num_sources; g++) begin : g_src
        assign src_valid[g] = src[g].valid;
        assign src_last[g]  = src[g].last;
        assign src_data[g]  = src[g].data;
        assign src_id[g]    = src[g].id;
        assign src_ready[g] = in_ready && (grant == taskwait_in_pkg::src_idx_t'(g));
        assign src[g].ready = src_ready[g]; // only the owner is ever ready.
    end

    // multiplexer of the granted source.
    always_comb begin
        sel_valid = 1'b0;
        sel_last  = 1'b0;
        sel_data  = '0;
        sel_id    = '0;
        for (int i = 0; i < taskwait_in_pkg::num_sources; i++) begin
            if (grant == taskwait_in_pkg::src_idx_t'(i)) begin
                sel_valid = src_valid[i];
                sel_last  = src_last[i];
                sel_data  = src_data[i];
                sel_id    = src_id[i];
            end
        end
    end

    assign in_ready    = grant_active && (count != 2'd2);
    assign in_fire     = in_ready && sel_valid;
    assign out_fire    = dst.valid && dst.ready;
    assign packet_done = in_fire && sel_last; // one pulse per packet.

    // payload entries.
    always_ff @(posedge clk) begin
        if (in_fire) begin
            buf_data[wr_ptr] <= sel_data;
            buf_id[wr_ptr]   <= sel_id;
            buf_last[wr_ptr] <= sel_last;
        end
    end

    // pointers and fill level.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (in_fire) wr_ptr <= ~wr_ptr;
            if (out_fire) rd_ptr <= ~rd_ptr;
            case ({in_fire, out_fire})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count; // both or neither.
            endcase
        end
    end

    // oldest entry drives the output.
    assign dst.valid = (count != 2'd0);
    assign dst.data  = buf_data[rd_ptr];
    assign dst.id    = buf_id[rd_ptr];
    assign dst.last  = buf_last[rd_ptr];

    // a stalled output beat stays put until it leaves.
    a_dst_hold: assert property (
        @(posedge clk) disable iff (rst)
        (dst.valid && !dst.ready) |=> (dst.valid && $stable(dst.data) && $stable(dst.id))
    ) else $error("output beat changed while stalled.");

    // the owner keeps the grant until its last beat, so no other source sees ready.
    a_ready_owner: assert property (
        @(posedge clk) disable iff (rst)
        (in_fire && !sel_last) |=> (grant_active && $stable(grant))
    ) else $error("ready moved to another source inside a packet.");

endmodule

/* hw/taskwait_in_switch.sv */
`timescale 1ns/1ns

// taskwait input merge.
// three task streams in, whole packets out on one stream without tlast.
module taskwait_in_switch (
    input  logic                      clk,
    input  logic                      rst,
    // taskwait requests.
    input  logic                      s00_tvalid,
    output logic                      s00_tready,
    input  taskwait_in_pkg::tw_data_t s00_tdata,
    input  taskwait_in_pkg::tw_id_t   s00_tid,
    input  logic                      s00_tlast,
    // acknowledgements.
    input  logic                      s01_tvalid,
    output logic                      s01_tready,
    input  taskwait_in_pkg::tw_data_t s01_tdata,
    input  taskwait_in_pkg::tw_id_t   s01_tid,
    input  logic                      s01_tlast,
    // spawn-queue notices.
    input  logic                      s02_tvalid,
    output logic                      s02_tready,
    input  taskwait_in_pkg::tw_data_t s02_tdata,
    input  taskwait_in_pkg::tw_id_t   s02_tid,
    input  logic                      s02_tlast,
    // merged output.
    output logic                      m00_tvalid,
    input  logic                      m00_tready,
    output taskwait_in_pkg::tw_data_t m00_tdata,
    output taskwait_in_pkg::tw_id_t   m00_tid
);

    axis_stream_if src_if [taskwait_in_pkg::num_sources] ();
    axis_stream_if dst_if ();

    taskwait_in_pkg::src_mask_t request;
    taskwait_in_pkg::src_idx_t  grant;
    taskwait_in_pkg::src_idx_t  prio;
    logic                       grant_active;
    logic                       packet_done;

    // pack the source ports.
    assign src_if[0].valid = s00_tvalid;
    assign src_if[0].data  = s00_tdata;
    assign src_if[0].id    = s00_tid;
    assign src_if[0].last  = s00_tlast;
    assign s00_tready      = src_if[0].ready;

    assign src_if[1].valid = s01_tvalid;
    assign src_if[1].data  = s01_tdata;
    assign src_if[1].id    = s01_tid;
    assign src_if[1].last  = s01_tlast;
    assign s01_tready      = src_if[1].ready;

    assign src_if[2].valid = s02_tvalid;
    assign src_if[2].data  = s02_tdata;
    assign src_if[2].id    = s02_tid;
    assign src_if[2].last  = s02_tlast;
    assign s02_tready      = src_if[2].ready;

    assign request = {src_if[2].valid, src_if[1].valid, src_if[0].valid};

    // unpack the output; last ends here.
    assign m00_tvalid   = dst_if.valid;
    assign m00_tdata    = dst_if.data;
    assign m00_tid      = dst_if.id;
    assign dst_if.ready = m00_tready;

    grant_fsm i_grant_fsm (
        .clk          (clk),
        .rst          (rst),
        .request      (request),
        .prio         (prio),
        .packet_done  (packet_done),
        .grant        (grant),
        .grant_active (grant_active)
    );

    rr_pointer i_rr_pointer (
        .clk         (clk),
        .rst         (rst),
        .packet_done (packet_done),
        .grant       (grant),
        .prio        (prio)
    );

    merge_slice i_merge_slice (
        .clk          (clk),
        .rst          (rst),
        .src          (src_if),
        .dst          (dst_if),
        .grant        (grant),
        .grant_active (grant_active),
        .packet_done  (packet_done)
    );

endmodule

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int error_count = 0; // failed checks over the whole run.

// payload of one beat.
task automatic check_data(input taskwait_in_pkg::tw_data_t got,
                          input taskwait_in_pkg::tw_data_t exp, input string what);
    if (got !== exp) begin
        $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
        error_count++;
    end
endtask

// task id of one beat.
task automatic check_id(input taskwait_in_pkg::tw_id_t got,
                        input taskwait_in_pkg::tw_id_t exp, input string what);
    if (got !== exp) begin
        $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
        error_count++;
    end
endtask

// handshake and status bits.
task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
        error_count++;
    end
endtask

// source that owned a packet on the output.
task automatic check_source(input taskwait_in_pkg::src_idx_t got,
                            input taskwait_in_pkg::src_idx_t exp, input string what);
    if (got !== exp) begin
        $display("** Error @ %0t: %s is %0d, expected %0d", $time, what, got, exp);
        error_count++;
    end
endtask

`endif

/* test/tb_taskwait_in_switch.sv */
`timescale 1ns/1ns

module tb_taskwait_in_switch;

    logic                      clk;
    logic                      rst;
    logic [2:0]                s_tvalid;
    wire  [2:0]                s_tready;
    taskwait_in_pkg::tw_data_t s_tdata [3];
    taskwait_in_pkg::tw_id_t   s_tid [3];
    logic [2:0]                s_tlast;
    logic                      m00_tvalid;
    logic                      m00_tready;
    taskwait_in_pkg::tw_data_t m00_tdata;
    taskwait_in_pkg::tw_id_t   m00_tid;

    // beats still to be offered for each source.
    taskwait_in_pkg::tw_data_t stim_data [3][$];
    taskwait_in_pkg::tw_id_t   stim_id [3][$];
    logic                      stim_last [3][$];
    // reference model of beats taken at each source and not yet seen on m00.
    taskwait_in_pkg::tw_data_t exp_data [3][$];
    taskwait_in_pkg::tw_id_t   exp_id [3][$];
    logic                      exp_last [3][$];
    taskwait_in_pkg::src_idx_t order_log [$]; // owner of each output packet.

    int seed = 32'h7d0c_1df9;
    int owner = -1;          // source whose packet is on m00 or -1 between packets.
    int beats_in = 0;
    int beats_out = 0;
    int planned_beats = 0;   // sets the timeout.
    int cycle_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic                      stall_seen = 1'b0;
    taskwait_in_pkg::tw_data_t stall_data;
    taskwait_in_pkg::tw_id_t   stall_id;

    `include "tb_checks.svh"

    taskwait_in_switch i_taskwait_in_switch (
        .clk(clk), .rst(rst),
        .s00_tvalid(s_tvalid[0]), .s00_tready(s_tready[0]), .s00_tdata(s_tdata[0]),
        .s00_tid(s_tid[0]), .s00_tlast(s_tlast[0]),
        .s01_tvalid(s_tvalid[1]), .s01_tready(s_tready[1]), .s01_tdata(s_tdata[1]),
        .s01_tid(s_tid[1]), .s01_tlast(s_tlast[1]),
        .s02_tvalid(s_tvalid[2]), .s02_tready(s_tready[2]), .s02_tdata(s_tdata[2]),
        .s02_tid(s_tid[2]), .s02_tlast(s_tlast[2]),
        .m00_tvalid(m00_tvalid), .m00_tready(m00_tready),
        .m00_tdata(m00_tdata), .m00_tid(m00_tid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period.
    end

    // watchdog at 40 cycles per generated beat plus margin.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 40 * planned_beats + 200) begin
            $display("timeout: the run stopped making progress after %0d cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // random packets of 1 to 4 beats for one source.
    task automatic make_packets(input int s, input int count);
        int len;
        for (int p = 0; p < count; p++) begin
            len = ($unsigned($random(seed)) % 4) + 1;
            for (int b = 0; b < len; b++) begin
                stim_data[s].push_back({$random(seed), $random(seed)});
                stim_id[s].push_back(taskwait_in_pkg::tw_id_t'($random(seed)));
                stim_last[s].push_back(b == len - 1);
            end
            planned_beats += len;
        end
    endtask

    // offers the queued beats of one source, with random valid gaps.
    task automatic drive_source(input int s, input int gap_max);
        int gap;
        while (stim_data[s].size() != 0) begin
            gap = (gap_max == 0) ? 0 : $unsigned($random(seed)) % (gap_max + 1);
            if (gap != 0) begin
                s_tvalid[s] = 1'b0;
                repeat (gap) @(posedge clk);
                #2;
            end
            s_tvalid[s] = 1'b1;
            s_tdata[s]  = stim_data[s].pop_front();
            s_tid[s]    = stim_id[s].pop_front();
            s_tlast[s]  = stim_last[s].pop_front();
            do @(negedge clk); while (s_tready[s] !== 1'b1); // beat leaves at next edge.
            @(posedge clk);
            #2;
        end
        s_tvalid[s] = 1'b0;
        s_tlast[s]  = 1'b0;
    endtask

    // random m00 back-pressure until the sources are empty.
    task automatic drive_ready_random();
        while (beats_out != beats_in || stim_data[0].size() != 0 ||
               stim_data[1].size() != 0 || stim_data[2].size() != 0) begin
            @(posedge clk);
            #2;
            m00_tready = ($unsigned($random(seed)) % 4) != 0;
        end
        m00_tready = 1'b1;
    endtask

    task automatic hold_output(input int cycles);
        m00_tready = 1'b0;
        repeat (cycles) @(posedge clk);
        #2;
        m00_tready = 1'b1;
    endtask

    task automatic wait_drain();
        do @(negedge clk); while (beats_out != beats_in || m00_tvalid !== 1'b0);
    endtask

    task automatic check_idle_outputs(input string when);
        check_flag(s_tready[0], 1'b0, {"s00 tready ", when});
        check_flag(s_tready[1], 1'b0, {"s01 tready ", when});
        check_flag(s_tready[2], 1'b0, {"s02 tready ", when});
        check_flag(m00_tvalid, 1'b0, {"m00 tvalid ", when});
    endtask

    // an output beat must continue the owner's packet or start a waiting one.
    task automatic take_output();
        int src;
        src = owner;
        beats_out++;
        for (int s = 0; s < 3; s++) begin
            if (src < 0 && exp_data[s].size() != 0 && exp_data[s][0] === m00_tdata &&
                exp_id[s][0] === m00_tid) begin
                src = s;
                order_log.push_back(taskwait_in_pkg::src_idx_t'(s));
            end
        end
        if (src < 0 || exp_data[src].size() == 0) begin
            $display("** Error @ %0t: m00 beat %h id %h fits no waiting packet",
                     $time, m00_tdata, m00_tid);
            error_count++;
            owner = -1;
            return;
        end
        check_data(m00_tdata, exp_data[src][0], "m00 tdata");
        check_id(m00_tid, exp_id[src][0], "m00 tid");
        owner = exp_last[src][0] ? -1 : src; // the output is free again after a last beat.
        void'(exp_data[src].pop_front());
        void'(exp_id[src].pop_front());
        void'(exp_last[src].pop_front());
    endtask

    // sampled mid-cycle, so a handshake seen here completes at the next edge.
    always @(negedge clk) begin
        if (!rst) begin
            for (int s = 0; s < 3; s++) begin
                if (s_tvalid[s] && s_tready[s]) begin
                    exp_data[s].push_back(s_tdata[s]);
                    exp_id[s].push_back(s_tid[s]);
                    exp_last[s].push_back(s_tlast[s]);
                    beats_in++;
                end
            end
            if (stall_seen) begin // beat held back at the last edge must still be there.
                check_flag(m00_tvalid, 1'b1, "m00 tvalid after stall");
                check_data(m00_tdata, stall_data, "m00 tdata after stall");
                check_id(m00_tid, stall_id, "m00 tid after stall");
            end
            stall_seen = m00_tvalid && !m00_tready;
            stall_data = m00_tdata;
            stall_id   = m00_tid;
            if (m00_tvalid && m00_tready) take_output();
        end
    end

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        int errs;
        int log_start;
        taskwait_in_pkg::tw_data_t lat_data;
        taskwait_in_pkg::tw_id_t   lat_id;
        rst        = 1'b1;
        s_tvalid   = '0;
        s_tlast    = '0;
        m00_tready = 1'b1;
        for (int s = 0; s < 3; s++) begin
            s_tdata[s] = '0;
            s_tid[s]   = '0;
        end

        errs = error_count;
        repeat (10) begin
            @(negedge clk);
            check_idle_outputs("in reset");
        end
        @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_idle_outputs("after reset");
        finish_test("reset_state", errs);

        // prio is 0 after reset and moves one past each served source.
        errs      = error_count;
        log_start = order_log.size();
        for (int s = 0; s < 3; s++) make_packets(s, 2);
        @(posedge clk);
        #2;
        fork
            drive_source(0, 0);
            drive_source(1, 0);
            drive_source(2, 0);
        join
        wait_drain();
        check_flag(order_log.size() == log_start + 6, 1'b1, "six packets out");
        for (int k = 0; k < 6 && log_start + k < order_log.size(); k++) begin
            check_source(order_log[log_start + k], taskwait_in_pkg::src_idx_t'(k % 3),
                         "packet owner");
        end
        finish_test("round_robin", errs);

        // a lone beat is granted at the first edge and taken at the second.
        errs     = error_count;
        lat_data = {$random(seed), $random(seed)};
        lat_id   = taskwait_in_pkg::tw_id_t'($random(seed));
        planned_beats++;
        @(posedge clk);
        #2;
        s_tvalid[1] = 1'b1;
        s_tdata[1]  = lat_data;
        s_tid[1]    = lat_id;
        s_tlast[1]  = 1'b1;
        @(negedge clk);
        check_flag(s_tready[1], 1'b0, "s01 tready before the grant edge");
        @(negedge clk);
        check_flag(s_tready[1], 1'b1, "s01 tready before the second edge");
        @(posedge clk);
        #2;
        s_tvalid[1] = 1'b0;
        s_tlast[1]  = 1'b0;
        @(negedge clk);
        check_flag(m00_tvalid, 1'b1, "m00 tvalid after the second edge");
        check_data(m00_tdata, lat_data, "m00 tdata of the lone beat");
        check_id(m00_tid, lat_id, "m00 tid of the lone beat");
        wait_drain();
        finish_test("fixed_latency", errs);

        errs = error_count;
        for (int s = 0; s < 3; s++) make_packets(s, 8);
        @(posedge clk);
        #2;
        fork
            drive_source(0, 3);
            drive_source(1, 3);
            drive_source(2, 3);
            drive_ready_random();
        join
        wait_drain();
        finish_test("random_traffic", errs);

        // long stall while all sources fill the buffer.
        errs = error_count;
        for (int s = 0; s < 3; s++) make_packets(s, 2);
        @(posedge clk);
        #2;
        fork
            drive_source(0, 1);
            drive_source(1, 1);
            drive_source(2, 1);
            hold_output(8 + $unsigned($random(seed)) % 16);
        join
        wait_drain();
        if (beats_out != beats_in || beats_in != planned_beats) begin
            $display("** Error @ %0t: %0d beats planned, %0d in, %0d out",
                     $time, planned_beats, beats_in, beats_out);
            error_count++;
        end
        finish_test("stall_no_loss", errs);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
hw/taskwait_in_pkg.sv
hw/axis_stream_if.sv
hw/grant_fsm.sv
hw/rr_pointer.sv
hw/merge_slice.sv
hw/taskwait_in_switch.sv
test/tb_taskwait_in_switch.sv

/* Makefile */
TOP = tb_taskwait_in_switch

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
